/* logic/cam_pkg.sv */
/* CAM package
   Sizes, vector types and request structs shared by the 8-entry CAM */
package cam_pkg;

  // Array geometry
  localparam int CAM_ELS    = 8;
  localparam int CAM_TAG_W  = 8;
  localparam int CAM_DATA_W = 16;
  // One node per internal vertex of the binary tree
  localparam int CAM_PLRU_W = CAM_ELS - 1;

  typedef logic [CAM_TAG_W-1:0]  cam_tag_t;
  typedef logic [CAM_DATA_W-1:0] cam_data_t;
  // One bit per entry, used for match, empty and select masks
  typedef logic [CAM_ELS-1:0]    cam_way_t;
  typedef logic [CAM_PLRU_W-1:0] cam_plru_t;

  // Write request, nuke invalidates the whole array
  typedef struct packed {
    logic      valid;
    logic      nuke;
    cam_tag_t  tag;
    cam_data_t data;
  } cam_wr_s;

  // Read request, looked up combinationally
  typedef struct packed {
    logic     valid;
    cam_tag_t tag;
  } cam_rd_s;

endpackage

/* logic/cam_tag_array.sv */
/* CAM tag array
   Tag and valid storage with parallel compare and per-entry set or global clear */
module cam_tag_array (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Write side
  input  cam_pkg::cam_way_t   set_i,
  input  logic                clear_all_i,
  input  cam_pkg::cam_tag_t   tag_i,
  output cam_pkg::cam_way_t   empty_o,
  // Read side
  input  logic                rd_v_i,
  input  cam_pkg::cam_tag_t   rd_tag_i,
  output cam_pkg::cam_way_t   match_o
);

  import cam_pkg::*;

  // Tag payload, only meaningful while the valid bit is set
  cam_tag_t tags_q [CAM_ELS];
  cam_way_t valid_q;

  // Valid bits
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
    end else if (clear_all_i) begin
      // Nuke drops every entry at once
      valid_q <= '0;
    end else begin
      valid_q <= valid_q | set_i;
    end
  end

  // Tag storage, written only in the allocated entry
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < CAM_ELS; i++) begin
      if (set_i[i]) begin
        tags_q[i] <= tag_i;
      end
    end
  end

  // Free entries feed the allocation choice
  assign empty_o = ~valid_q;

  // Parallel compare against every valid entry
  always_comb begin
    match_o = '0;
    for (int i = 0; i < CAM_ELS; i++) begin
      match_o[i] = rd_v_i && valid_q[i] && (tags_q[i] == rd_tag_i);
    end
  end

  // At most one entry allocated per write, and never during a nuke
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $onehot0(set_i) && !(clear_all_i && (set_i != '0)))
    else $error("tag array set mask not one-hot or collides with clear at %0t", $time);

endmodule

/* logic/cam_replacement.sv */
/* CAM replacement
   Tree pseudo-LRU state with lowest-empty-first allocation of one entry */
module cam_replacement (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Read hits refresh the tree
  input  cam_pkg::cam_way_t   touch_i,
  // Allocation request and free entries
  input  logic                alloc_v_i,
  input  cam_pkg::cam_way_t   empty_i,
  output cam_pkg::cam_way_t   alloc_o
);

  import cam_pkg::*;

  localparam int IDX_W = $clog2(CAM_ELS);

  typedef logic [IDX_W-1:0] idx_t;

  cam_plru_t plru_q;
  cam_plru_t plru_d;
  idx_t      touch_idx;
  idx_t      empty_idx;
  idx_t      victim_idx;
  idx_t      alloc_idx;

  // Lowest set bit of a mask wins so entry 0 has priority
  function automatic idx_t lowest_idx(cam_way_t mask);
    idx_t idx;
    idx = '0;
    for (int i = CAM_ELS - 1; i >= 0; i--) begin
      if (mask[i]) begin
        idx = idx_t'(i);
      end
    end
    return idx;
  endfunction

  // Walk from the root where 0 goes left and 1 goes right
  function automatic idx_t plru_victim(cam_plru_t state);
    idx_t victim;
    int   node;
    victim = '0;
    node   = 0;
    for (int lvl = 0; lvl < IDX_W; lvl++) begin
      victim[IDX_W-1-lvl] = state[node];
      node = 2 * node + 1 + int'(state[node]);
    end
    return victim;
  endfunction

  // Every node on the path now points away from the touched entry
  function automatic cam_plru_t plru_touch(cam_plru_t state, idx_t idx);
    cam_plru_t next;
    int        node;
    logic      dir;
    next = state;
    node = 0;
    for (int lvl = 0; lvl < IDX_W; lvl++) begin
      dir        = idx[IDX_W-1-lvl];
      next[node] = ~dir;
      node       = 2 * node + 1 + int'(dir);
    end
    return next;
  endfunction

  assign touch_idx  = lowest_idx(touch_i);
  assign empty_idx  = lowest_idx(empty_i);
  assign victim_idx = plru_victim(plru_q);
  // Free entry beats eviction
  assign alloc_idx  = (empty_i != '0) ? empty_idx : victim_idx;
  assign alloc_o    = alloc_v_i ? (cam_way_t'(1) << alloc_idx) : '0;

  // Read touch first and allocation last so it owns shared nodes
  always_comb begin
    plru_d = plru_q;
    if (touch_i != '0) begin
      plru_d = plru_touch(plru_d, touch_idx);
    end
    if (alloc_v_i) begin
      plru_d = plru_touch(plru_d, alloc_idx);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      plru_q <= '0;
    end else begin
      plru_q <= plru_d;
    end
  end

  // The entry just allocated is never the next victim
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    alloc_v_i |=> (victim_idx != $past(alloc_idx)))
    else $error("replacement victim repeats the entry just allocated at %0t", $time);

endmodule

/* logic/cam_data_array.sv */
/* CAM data array
   Data words with one-hot write and OR-reduced read of all selected entries */
module cam_data_array (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // One-hot write from the allocation
  input  cam_pkg::cam_way_t   wr_sel_i,
  input  cam_pkg::cam_data_t  wr_data_i,
  // Match mask from the tag array
  input  cam_pkg::cam_way_t   rd_sel_i,
  output cam_pkg::cam_data_t  rd_data_o
);

  import cam_pkg::*;

  cam_data_t data_q [CAM_ELS];

  // Words start at zero
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < CAM_ELS; i++) begin
        data_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < CAM_ELS; i++) begin
        if (wr_sel_i[i]) begin
          data_q[i] <= wr_data_i;
        end
      end
    end
  end

  // Duplicate tags return the OR of their words, no match gives zero
  always_comb begin
    rd_data_o = '0;
    for (int i = 0; i < CAM_ELS; i++) begin
      if (rd_sel_i[i]) begin
        rd_data_o = rd_data_o | data_q[i];
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!arst_n_i) $onehot0(wr_sel_i))
    else $error("data array write select not one-hot at %0t", $time);

endmodule

/* logic/cam_1r1w.sv */
/* CAM top, 8 entries with one async read port and one sync write port
   Pseudo-LRU replacement, nuke write invalidates the whole array */
module cam_1r1w (
  input  logic                clk_i,
  input  logic                arst_n_i,
  // Write or nuke request
  input  cam_pkg::cam_wr_s    wr_i,
  // Combinational lookup
  input  cam_pkg::cam_rd_s    rd_i,
  output cam_pkg::cam_data_t  rd_data_o,
  output logic                rd_hit_o
);

  import cam_pkg::*;

  cam_way_t match;
  cam_way_t empty;
  cam_way_t alloc;
  logic     nuke_clear;
  logic     alloc_v;

  // Nuke only clears, plain write allocates
  assign nuke_clear = wr_i.valid & wr_i.nuke;
  assign alloc_v    = wr_i.valid & ~wr_i.nuke;

  cam_tag_array u_tag_array (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .set_i       (alloc),
    .clear_all_i (nuke_clear),
    .tag_i       (wr_i.tag),
    .empty_o     (empty),
    .rd_v_i      (rd_i.valid),
    .rd_tag_i    (rd_i.tag),
    .match_o     (match)
  );

  // Read hits count as use for the tree
  cam_replacement u_replacement (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .touch_i   (match),
    .alloc_v_i (alloc_v),
    .empty_i   (empty),
    .alloc_o   (alloc)
  );

  cam_data_array u_data_array (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .wr_sel_i  (alloc),
    .wr_data_i (wr_i.data),
    .rd_sel_i  (match),
    .rd_data_o (rd_data_o)
  );

  // Match is already qualified by read valid
  assign rd_hit_o = |match;

endmodule

/* tb/cam_tb.sv */
/* CAM testbench
   Reference model fills a stimulus table with expected read results, then replays it */
module cam_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import cam_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 4;
  localparam int RANDOM_STEPS = 200;
  localparam int LEVELS       = $clog2(CAM_ELS);

  // One row per cycle, stimulus plus the model's expected read result
  typedef struct packed {
    logic      wr_v;
    logic      nuke;
    cam_tag_t  wr_tag;
    cam_data_t wr_data;
    logic      rd_v;
    cam_tag_t  rd_tag;
    logic      exp_hit;
    cam_data_t exp_data;
  } step_s;

  logic      clk;
  logic      arst_n;
  cam_wr_s   wr_req;
  cam_rd_s   rd_req;
  cam_data_t rd_data;
  logic      rd_hit;

  step_s     table_q [$];
  bit        table_ready = 1'b0;
  int        error_count = 0;

  // Reference state
  cam_tag_t  m_tag [CAM_ELS];
  cam_data_t m_data [CAM_ELS];
  cam_way_t  m_valid;
  cam_plru_t m_plru;

  cam_1r1w u_cam_1r1w (
    .clk_i     (clk),
    .arst_n_i  (arst_n),
    .wr_i      (wr_req),
    .rd_i      (rd_req),
    .rd_data_o (rd_data),
    .rd_hit_o  (rd_hit)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Level l of the heap starts at node 2^l - 1, offset by the path taken so far
  function automatic int find_victim();
    int way;
    way = 0;
    for (int l = 0; l < LEVELS; l++) begin
      way = 2 * way + int'(m_plru[(1 << l) - 1 + way]);
    end
    return way;
  endfunction

  // Nodes on the path point to the other half
  task automatic touch_way(input int way);
    for (int l = 0; l < LEVELS; l++) begin
      m_plru[(1 << l) - 1 + (way >> (LEVELS - l))] = ~way[LEVELS - 1 - l];
    end
  endtask

  // Expected read from the old contents, then the model takes the write
  task automatic add_step(input logic wr_v, input logic nuke, input cam_tag_t wr_tag,
                          input cam_data_t wr_data, input logic rd_v, input cam_tag_t rd_tag);
    step_s s;
    int    hit_way;
    int    alloc_way;
    s = '{wr_v: wr_v, nuke: nuke, wr_tag: wr_tag, wr_data: wr_data, rd_v: rd_v,
          rd_tag: rd_tag, exp_hit: 1'b0, exp_data: '0};
    hit_way = -1;
    for (int i = 0; i < CAM_ELS; i++) begin
      if (rd_v && m_valid[i] && (m_tag[i] == rd_tag)) begin
        s.exp_hit  = 1'b1;
        s.exp_data = s.exp_data | m_data[i];
        if (hit_way < 0) begin
          hit_way = i;
        end
      end
    end
    // Victim comes from the stored state, a free entry wins over it
    alloc_way = find_victim();
    for (int i = CAM_ELS - 1; i >= 0; i--) begin
      if (!m_valid[i]) begin
        alloc_way = i;
      end
    end
    if (hit_way >= 0) begin
      touch_way(hit_way);
    end
    if (wr_v && nuke) begin
      // Tree state survives the nuke
      m_valid = '0;
    end else if (wr_v) begin
      m_valid[alloc_way] = 1'b1;
      m_tag[alloc_way]   = wr_tag;
      m_data[alloc_way]  = wr_data;
      touch_way(alloc_way);
    end
    table_q.push_back(s);
  endtask

  task automatic add_read(input cam_tag_t tag);
    add_step(1'b0, 1'b0, '0, '0, 1'b1, tag);
  endtask

  task automatic add_write(input cam_tag_t tag, input cam_data_t data);
    add_step(1'b1, 1'b0, tag, data, 1'b0, '0);
  endtask

  task automatic read_all_known();
    for (int i = 0; i < CAM_ELS; i++) begin
      add_read(cam_tag_t'(8'hA0 + i));
    end
    add_read(8'hB0);
    add_read(8'hB1);
  endtask

  initial begin : stimulus
    step_s       s;
    integer      seed;
    logic [31:0] r_ctl;
    logic [31:0] r_wtag;
    logic [31:0] r_data;
    logic [31:0] r_rtag;
    cam_tag_t    victim_tag;
    arst_n  = 1'b0;
    wr_req  = '0;
    rd_req  = '0;
    m_valid = '0;
    m_plru  = '0;
    seed    = 76;

    // Empty array after reset
    add_read(8'h00);
    add_read(8'h5A);
    add_read(8'hA3);
    // Fill in order, same-cycle read misses and the next cycle hits
    for (int i = 0; i < CAM_ELS; i++) begin
      add_step(1'b1, 1'b0, cam_tag_t'(8'hA0 + i), cam_data_t'(16'h1000 + 16'h0111 * i),
               1'b1, cam_tag_t'(8'hA0 + i));
      add_read(cam_tag_t'(8'hA0 + i));
    end
    // Full array, write with no read evicts the tree victim
    add_write(8'hB0, 16'hB0B0);
    read_all_known();
    // Hit on the predicted victim moves the victim elsewhere
    victim_tag = m_tag[find_victim()];
    add_read(victim_tag);
    add_write(8'hB1, 16'hB1B1);
    read_all_known();
    // Nuke, then refill from entry 0
    add_step(1'b1, 1'b1, '0, '0, 1'b0, '0);
    read_all_known();
    add_write(8'hC0, 16'hC0C0);
    add_write(8'hC1, 16'hC1C1);
    add_write(8'hC2, 16'hC2C2);
    add_read(8'hC0);
    add_read(8'hC1);
    add_read(8'hC2);
    // Duplicate tag, read ORs both words
    add_write(8'hDD, 16'h00F0);
    add_write(8'hDD, 16'h0F0F);
    add_read(8'hDD);

    // Random tail over 12 tags, rare nukes
    for (int n = 0; n < RANDOM_STEPS; n++) begin
      r_ctl  = $random(seed);
      r_wtag = $random(seed);
      r_data = $random(seed);
      r_rtag = $random(seed);
      add_step(r_ctl[0], r_ctl[8:4] == 5'd0, cam_tag_t'(8'h40 + (r_wtag % 12)),
               cam_data_t'(r_data), r_ctl[1], cam_tag_t'(8'h40 + (r_rtag % 12)));
    end
    table_ready = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;

    foreach (table_q[k]) begin
      s = table_q[k];
      @(posedge clk);
      wr_req <= '{valid: s.wr_v, nuke: s.nuke, tag: s.wr_tag, data: s.wr_data};
      rd_req <= '{valid: s.rd_v, tag: s.rd_tag};
      // Sample mid-cycle, read path is combinational
      #(CLK_PERIOD / 2);
      assert ((rd_hit === s.exp_hit) && (rd_data === s.exp_data))
        else begin
          error_count++;
          $display("Mismatch at %0t: step %0d tag %h got hit %0b data %h, expected hit %0b data %h",
                   $time, k, s.rd_tag, rd_hit, rd_data, s.exp_hit, s.exp_data);
        end
    end

    $display("Checked %0d steps, %0d errors", table_q.size(), error_count);
    if (error_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // Twice the expected run length
  initial begin : watchdog
    wait (table_ready);
    #((table_q.size() + RESET_CYCLES) * CLK_PERIOD * 2);
    $display("Timeout: the run did not finish in the expected time");
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

/* files.f */
logic/cam_pkg.sv
logic/cam_tag_array.sv
logic/cam_replacement.sv
logic/cam_data_array.sv
logic/cam_1r1w.sv
tb/cam_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the CAM testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module cam_tb \
  -Mdir obj_dir -o cam_tb_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

sim_output=$(./obj_dir/cam_tb_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ "$sim_status" -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "SIMULATION PASSED" <<< "$sim_output"; then
  exit 0
fi
exit 1
